// ==== logic/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Execute stage sizing
////////////////////////////////////////////////////////////////////////////

// Integer data path width
`define EXEC_XLEN 32

// Register file address width, 32 registers
`define EXEC_REG_BITS 5

// Shift-add iterations, one multiplier bit per cycle
`define EXEC_MUL_CYCLES 32

`endif

// ==== logic/exec_pkg.sv ====
package exec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Decoded control encodings for the execute stage
  ////////////////////////////////////////////////////////////////////////////

  // ALU operation
  typedef enum logic [3:0] {
    alu_add   = 4'd0,
    alu_sub   = 4'd1,
    alu_sll   = 4'd2,
    alu_slt   = 4'd3,
    alu_sltu  = 4'd4,
    alu_xor   = 4'd5,
    alu_srl   = 4'd6,
    alu_sra   = 4'd7,
    alu_or    = 4'd8,
    alu_and   = 4'd9,
    // Pass operand b, the upper immediate
    alu_lui   = 4'd10,
    // PC plus operand b
    alu_auipc = 4'd11,
    // Return address, PC plus 4
    alu_link  = 4'd12
  } alu_op_t;

  // Branch-style comparison of the two operands
  typedef enum logic [2:0] {
    comp_eq  = 3'd0,
    comp_ne  = 3'd1,
    comp_lt  = 3'd2,
    comp_ge  = 3'd3,
    comp_ltu = 3'd4,
    comp_geu = 3'd5
  } comp_op_t;

  // Multiply variant, low word or one of the high words
  typedef enum logic [1:0] {
    mul_low = 2'd0,
    mul_h   = 2'd1,
    mul_hsu = 2'd2,
    mul_hu  = 2'd3
  } mul_op_t;

  // Result source for the EX/MEM register
  typedef enum logic {
    unit_alu = 1'b0,
    unit_mul = 1'b1
  } unit_t;

endpackage : exec_pkg

// ==== logic/exmem_fwd_if.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

// EX/MEM register contents looped back for operand forwarding
interface exmem_fwd_if;

  // Destination register of the older instruction
  logic [`EXEC_REG_BITS-1:0] rd;
  // Writes the register file
  logic                      regwrite;
  // Load, data not known until MEM
  logic                      memread;
  // ALU or multiply result held in EX/MEM
  logic [`EXEC_XLEN-1:0]     result;

  // Pipeline register side
  modport source (
    output rd,
    output regwrite,
    output memread,
    output result
  );

  // Forwarding unit side
  modport sink (
    input rd,
    input regwrite,
    input memread,
    input result
  );

endinterface : exmem_fwd_if

// ==== logic/forwarding.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module forwarding (
  input  logic [`EXEC_REG_BITS-1:0] id_ex_rs1,
  input  logic [`EXEC_REG_BITS-1:0] id_ex_rs2,
  input  logic [`EXEC_XLEN-1:0]     id_ex_rs1_data,
  input  logic [`EXEC_XLEN-1:0]     id_ex_rs2_data,
  input  logic [`EXEC_XLEN-1:0]     id_ex_imm,
  input  logic                      id_ex_alusrc,
  input  logic                      mem_wb_regwrite,
  input  logic [`EXEC_REG_BITS-1:0] mem_wb_rd,
  input  logic [`EXEC_XLEN-1:0]     mem_wb_result,
  exmem_fwd_if.sink                 fwd,
  output logic [`EXEC_XLEN-1:0]     op_a,
  output logic [`EXEC_XLEN-1:0]     op_b,
  output logic [`EXEC_XLEN-1:0]     store_data
);

  // EX/MEM can supply a value, loads excluded
  logic                  ex_valid;
  // MEM/WB can supply a value
  logic                  wb_valid;
  // Resolved source registers
  logic [`EXEC_XLEN-1:0] rs1_value;
  logic [`EXEC_XLEN-1:0] rs2_value;

  ////////////////////////////////////////////////////////////////////////////
  // Per-stage qualifiers
  ////////////////////////////////////////////////////////////////////////////

  // x0 never forwards, it reads as zero from the file
  assign ex_valid = fwd.regwrite && !fwd.memread && (fwd.rd != '0);
  assign wb_valid = mem_wb_regwrite && (mem_wb_rd != '0);

  // Priority pick for one source register
  function automatic logic [`EXEC_XLEN-1:0] resolve(
    input logic [`EXEC_REG_BITS-1:0] rs,
    input logic [`EXEC_XLEN-1:0]     rf_value
  );
    logic [`EXEC_XLEN-1:0] pick;
    // Lowest priority, register file read in decode
    pick = rf_value;
    // Next, the instruction two ahead in MEM/WB
    if (wb_valid && (mem_wb_rd == rs)) begin
      pick = mem_wb_result;
    end
    // Highest, the instruction directly ahead in EX/MEM
    if (ex_valid && (fwd.rd == rs)) begin
      pick = fwd.result;
    end
    return pick;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rs1_value = resolve(id_ex_rs1, id_ex_rs1_data);
    rs2_value = resolve(id_ex_rs2, id_ex_rs2_data);
  end

  assign op_a = rs1_value;
  // Immediate replaces rs2 for I-type, loads, stores, lui, auipc
  assign op_b = id_ex_alusrc ? id_ex_imm : rs2_value;
  // Stores always write the forwarded rs2
  assign store_data = rs2_value;

endmodule : forwarding

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module alu (
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  input  logic [`EXEC_XLEN-1:0] pc,
  input  exec_pkg::alu_op_t     alu_op,
  input  exec_pkg::comp_op_t    comp_op,
  output logic [`EXEC_XLEN-1:0] result,
  output logic                  comp_res
);
  import exec_pkg::*;

  // Shift amount, low five bits of b
  logic [4:0]            shamt;
  // Shared comparator terms
  logic                  eq;
  logic                  lt_s;
  logic                  lt_u;
  logic [`EXEC_XLEN-1:0] sum;
  logic [`EXEC_XLEN-1:0] diff;

  assign shamt = b[4:0];
  assign sum   = a + b;
  assign diff  = a - b;

  assign eq   = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      alu_add:   result = sum;
      alu_sub:   result = diff;
      alu_sll:   result = a << shamt;
      // Set-less-than, zero extended flag
      alu_slt:   result = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
      alu_sltu:  result = {{(`EXEC_XLEN-1){1'b0}}, lt_u};
      alu_xor:   result = a ^ b;
      alu_srl:   result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      alu_sra:   result = $signed(a) >>> shamt;
      alu_or:    result = a | b;
      alu_and:   result = a & b;
      // Immediate already shifted in decode
      alu_lui:   result = b;
      alu_auipc: result = pc + b;
      // jal and jalr write the address after the jump
      alu_link:  result = pc + `EXEC_XLEN'(4);
      default:   result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (comp_op)
      comp_eq:  comp_res = eq;
      comp_ne:  comp_res = !eq;
      comp_lt:  comp_res = lt_s;
      comp_ge:  comp_res = !lt_s;
      comp_ltu: comp_res = lt_u;
      comp_geu: comp_res = !lt_u;
      // Unused codes never pass
      default:  comp_res = 1'b0;
    endcase
  end

endmodule : alu

// ==== logic/multiplier.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module multiplier (
  input  logic                  bus,
  input  logic                  reset,
  input  logic                  request,
  input  logic                  advance,
  input  exec_pkg::mul_op_t     mul_op,
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  output logic                  busy,
  output logic                  done,
  output logic [`EXEC_XLEN-1:0] result
);
  import exec_pkg::*;

  localparam int cnt_bits = $clog2(`EXEC_MUL_CYCLES);

  logic [cnt_bits-1:0]     count;
  logic                    start;
  logic                    last;
  // Operand sign handling
  logic                    a_signed;
  logic                    b_signed;
  logic                    a_neg;
  logic                    b_neg;
  logic [`EXEC_XLEN-1:0]   a_mag;
  logic [`EXEC_XLEN-1:0]   b_mag;
  // Iteration state
  logic [2*`EXEC_XLEN-1:0] mcand;
  logic [`EXEC_XLEN-1:0]   mplier;
  logic [2*`EXEC_XLEN-1:0] acc;
  logic                    neg_q;
  mul_op_t                 op_q;
  logic [2*`EXEC_XLEN-1:0] product;

  // New operation only from idle with no result waiting
  assign start = request && !busy && !done;
  assign last  = busy && (count == cnt_bits'(`EXEC_MUL_CYCLES - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Magnitudes
  ////////////////////////////////////////////////////////////////////////////

  // mulhu is fully unsigned, mulhsu signs a only
  // Low word is the same either way
  assign a_signed = (mul_op != mul_hu);
  assign b_signed = (mul_op == mul_low) || (mul_op == mul_h);

  assign a_neg = a_signed && a[`EXEC_XLEN-1];
  assign b_neg = b_signed && b[`EXEC_XLEN-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else begin
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (last) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else if (busy) begin
        count <= count + 1'b1;
      end
      // Result waits until EX/MEM takes it
      if (done && advance) begin
        done <= 1'b0;
      end
    end
  end

  // Shift-add, one multiplier bit per cycle
  always_ff @(posedge bus) begin
    if (start) begin
      acc    <= '0;
      mcand  <= {{`EXEC_XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      neg_q  <= a_neg ^ b_neg;
      op_q   <= mul_op;
    end else if (busy) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Sign restore, then pick the word
  assign product = neg_q ? -acc : acc;
  assign result  = (op_q == mul_low) ? product[`EXEC_XLEN-1:0]
                                     : product[2*`EXEC_XLEN-1:`EXEC_XLEN];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_busy_len: assert property (@(posedge bus) disable iff (reset)
    $rose(busy) |-> busy [* `EXEC_MUL_CYCLES] ##1 !busy)
    else $error("multiplier busy window has the wrong length");

  a_busy_done: assert property (@(posedge bus) disable iff (reset)
    !(busy && done))
    else $error("multiplier busy and done both high");

endmodule : multiplier

// ==== logic/execute.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module execute (
  input  logic                      bus,
  input  logic                      reset,
  input  logic                      dbg,
  input  logic                      mem_hold,
  input  logic [`EXEC_XLEN-1:0]     id_ex_pc,
  input  logic [`EXEC_REG_BITS-1:0] id_ex_rs1,
  input  logic [`EXEC_REG_BITS-1:0] id_ex_rs2,
  input  logic [`EXEC_REG_BITS-1:0] id_ex_rd,
  input  logic [`EXEC_XLEN-1:0]     id_ex_rs1_data,
  input  logic [`EXEC_XLEN-1:0]     id_ex_rs2_data,
  input  logic [`EXEC_XLEN-1:0]     id_ex_imm,
  input  exec_pkg::alu_op_t         id_ex_alu_op,
  input  exec_pkg::comp_op_t        id_ex_comp_op,
  input  logic                      id_ex_compare,
  input  logic                      id_ex_alusrc,
  input  exec_pkg::unit_t           id_ex_unit,
  input  exec_pkg::mul_op_t         id_ex_mul_op,
  input  logic                      id_ex_memread,
  input  logic                      id_ex_memwrite,
  input  logic                      id_ex_regwrite,
  input  logic                      mem_wb_regwrite,
  input  logic [`EXEC_REG_BITS-1:0] mem_wb_rd,
  input  logic [`EXEC_XLEN-1:0]     mem_wb_result,
  output logic                      ex_stall,
  output logic [`EXEC_XLEN-1:0]     ex_mem_result,
  output logic [`EXEC_XLEN-1:0]     ex_mem_store_data,
  output logic [`EXEC_XLEN-1:0]     ex_mem_pc,
  output logic [`EXEC_REG_BITS-1:0] ex_mem_rd,
  output logic                      ex_mem_memread,
  output logic                      ex_mem_memwrite,
  output logic                      ex_mem_regwrite,
  output logic                      ex_mem_comp_res
);
  import exec_pkg::*;

  // Resolved operands
  logic [`EXEC_XLEN-1:0] op_a;
  logic [`EXEC_XLEN-1:0] op_b;
  logic [`EXEC_XLEN-1:0] store_data;
  // Unit results
  logic [`EXEC_XLEN-1:0] alu_res;
  logic [`EXEC_XLEN-1:0] mul_res;
  logic                  comp_res;
  logic                  mul_req;
  logic                  mul_busy;
  logic                  mul_done;
  // Stage hold
  logic                  freeze;

  exmem_fwd_if fwd_if0 ();

  // Loop EX/MEM back to forwarding
  assign fwd_if0.rd       = ex_mem_rd;
  assign fwd_if0.regwrite = ex_mem_regwrite;
  assign fwd_if0.memread  = ex_mem_memread;
  assign fwd_if0.result   = ex_mem_result;

  forwarding fwd0 (
    .id_ex_rs1       (id_ex_rs1),
    .id_ex_rs2       (id_ex_rs2),
    .id_ex_rs1_data  (id_ex_rs1_data),
    .id_ex_rs2_data  (id_ex_rs2_data),
    .id_ex_imm       (id_ex_imm),
    .id_ex_alusrc    (id_ex_alusrc),
    .mem_wb_regwrite (mem_wb_regwrite),
    .mem_wb_rd       (mem_wb_rd),
    .mem_wb_result   (mem_wb_result),
    .fwd             (fwd_if0.sink),
    .op_a            (op_a),
    .op_b            (op_b),
    .store_data      (store_data)
  );

  alu alu0 (
    .a        (op_a),
    .b        (op_b),
    .pc       (id_ex_pc),
    .alu_op   (id_ex_alu_op),
    .comp_op  (id_ex_comp_op),
    .result   (alu_res),
    .comp_res (comp_res)
  );

  multiplier mul0 (
    .bus     (bus),
    .reset   (reset),
    .request (mul_req),
    .advance (!freeze),
    .mul_op  (id_ex_mul_op),
    .a       (op_a),
    .b       (op_b),
    .busy    (mul_busy),
    .done    (mul_done),
    .result  (mul_res)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stall and freeze
  ////////////////////////////////////////////////////////////////////////////

  assign mul_req  = (id_ex_unit == unit_mul);
  // Held until the product is ready
  assign ex_stall = mul_req && !mul_done;
  assign freeze   = dbg || mem_hold || ex_stall;

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      ex_mem_result     <= '0;
      ex_mem_store_data <= '0;
      ex_mem_pc         <= '0;
      ex_mem_rd         <= '0;
      ex_mem_memread    <= 1'b0;
      ex_mem_memwrite   <= 1'b0;
      ex_mem_regwrite   <= 1'b0;
      ex_mem_comp_res   <= 1'b0;
    end else if (!freeze) begin
      ex_mem_result     <= mul_req ? mul_res : alu_res;
      ex_mem_store_data <= store_data;
      ex_mem_pc         <= id_ex_pc;
      ex_mem_rd         <= id_ex_rd;
      ex_mem_memread    <= id_ex_memread;
      ex_mem_memwrite   <= id_ex_memwrite;
      // Failed comparison cancels the write
      ex_mem_regwrite   <= id_ex_regwrite && (!id_ex_compare || comp_res);
      ex_mem_comp_res   <= comp_res;
    end
  end

  // Decode never issues a load and store together
  a_mem_excl: assert property (@(posedge bus) disable iff (reset)
    !(ex_mem_memread && ex_mem_memwrite))
    else $error("EX/MEM memread and memwrite both high");

  // Running multiplier always holds the stage
  a_busy_stall: assert property (@(posedge bus) disable iff (reset)
    mul_busy |-> ex_stall)
    else $error("multiplier busy without ex_stall");

endmodule : execute

// ==== testbench/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

`include "exec_params.svh"

////////////////////////////////////////////////////////////////////////////
// Reference results from the RV32I and RV32M definitions
////////////////////////////////////////////////////////////////////////////

// Integer op result, shift amount from the low five bits
function automatic logic [`EXEC_XLEN-1:0] ref_alu(
  input alu_op_t               op,
  input logic [`EXEC_XLEN-1:0] a,
  input logic [`EXEC_XLEN-1:0] b,
  input logic [`EXEC_XLEN-1:0] pc
);
  logic [4:0]            sh;
  logic [`EXEC_XLEN-1:0] fill;
  sh = b[4:0];
  // Sign fill for the arithmetic right shift
  fill = a[`EXEC_XLEN-1] ? ~({`EXEC_XLEN{1'b1}} >> sh) : '0;
  case (op)
    alu_add:   return a + b;
    alu_sub:   return a + ~b + `EXEC_XLEN'(1);
    alu_sll:   return a << sh;
    alu_slt:   return ($signed(a) < $signed(b)) ? `EXEC_XLEN'(1) : '0;
    alu_sltu:  return (a < b) ? `EXEC_XLEN'(1) : '0;
    alu_xor:   return a ^ b;
    alu_srl:   return a >> sh;
    alu_sra:   return (a >> sh) | fill;
    alu_or:    return a | b;
    alu_and:   return a & b;
    alu_lui:   return b;
    alu_auipc: return pc + b;
    alu_link:  return pc + `EXEC_XLEN'(4);
    default:   return '0;
  endcase
endfunction

// Branch condition
function automatic logic ref_comp(
  input comp_op_t              op,
  input logic [`EXEC_XLEN-1:0] a,
  input logic [`EXEC_XLEN-1:0] b
);
  case (op)
    comp_eq:  return a == b;
    comp_ne:  return a != b;
    comp_lt:  return $signed(a) < $signed(b);
    comp_ge:  return $signed(a) >= $signed(b);
    comp_ltu: return a < b;
    comp_geu: return a >= b;
    default:  return 1'b0;
  endcase
endfunction

// Full product of the extended operands, then pick the word
function automatic logic [`EXEC_XLEN-1:0] ref_mul(
  input mul_op_t               op,
  input logic [`EXEC_XLEN-1:0] a,
  input logic [`EXEC_XLEN-1:0] b
);
  logic [2*`EXEC_XLEN-1:0] ea;
  logic [2*`EXEC_XLEN-1:0] eb;
  logic [2*`EXEC_XLEN-1:0] p;
  // mulhu zero extends a, mulhsu and mulhu zero extend b
  ea = (op == mul_hu) ? {{`EXEC_XLEN{1'b0}}, a} : {{`EXEC_XLEN{a[`EXEC_XLEN-1]}}, a};
  eb = (op == mul_hsu || op == mul_hu) ? {{`EXEC_XLEN{1'b0}}, b}
                                       : {{`EXEC_XLEN{b[`EXEC_XLEN-1]}}, b};
  p = ea * eb;
  return (op == mul_low) ? p[`EXEC_XLEN-1:0] : p[2*`EXEC_XLEN-1:`EXEC_XLEN];
endfunction

`endif

// ==== testbench/tb_execute.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module tb_execute;
  import exec_pkg::*;

  `include "exec_model.svh"

  localparam int period_ns = 40;
  // Upper bounds on instructions per test group
  localparam int num_alu = 40;
  localparam int num_fwd = 12;
  localparam int num_cmp = 24;
  localparam int num_mul = 24;
  localparam int num_frz = 6;
  localparam int total_instr = num_alu + num_fwd + num_cmp + num_mul + num_frz;

  // One EX/MEM register image
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]     result;
    logic [`EXEC_XLEN-1:0]     store_data;
    logic [`EXEC_XLEN-1:0]     pc;
    logic [`EXEC_REG_BITS-1:0] rd;
    logic                      memread;
    logic                      memwrite;
    logic                      regwrite;
    logic                      comp_res;
  } exmem_t;

  // ID/EX fields plus the MEM/WB values driven alongside
  typedef struct packed {
    logic [`EXEC_XLEN-1:0]     pc;
    logic [`EXEC_REG_BITS-1:0] rs1;
    logic [`EXEC_REG_BITS-1:0] rs2;
    logic [`EXEC_REG_BITS-1:0] rd;
    logic [`EXEC_XLEN-1:0]     rs1_data;
    logic [`EXEC_XLEN-1:0]     rs2_data;
    logic [`EXEC_XLEN-1:0]     imm;
    alu_op_t                   alu_op;
    comp_op_t                  comp_op;
    logic                      compare;
    logic                      alusrc;
    unit_t                     unit;
    mul_op_t                   mul_op;
    logic                      memread;
    logic                      memwrite;
    logic                      regwrite;
    logic                      wb_regwrite;
    logic [`EXEC_REG_BITS-1:0] wb_rd;
    logic [`EXEC_XLEN-1:0]     wb_result;
  } instr_t;

  logic                      bus;
  logic                      reset;
  logic                      dbg;
  logic                      mem_hold;
  logic [`EXEC_XLEN-1:0]     id_ex_pc;
  logic [`EXEC_REG_BITS-1:0] id_ex_rs1;
  logic [`EXEC_REG_BITS-1:0] id_ex_rs2;
  logic [`EXEC_REG_BITS-1:0] id_ex_rd;
  logic [`EXEC_XLEN-1:0]     id_ex_rs1_data;
  logic [`EXEC_XLEN-1:0]     id_ex_rs2_data;
  logic [`EXEC_XLEN-1:0]     id_ex_imm;
  alu_op_t                   id_ex_alu_op;
  comp_op_t                  id_ex_comp_op;
  logic                      id_ex_compare;
  logic                      id_ex_alusrc;
  unit_t                     id_ex_unit;
  mul_op_t                   id_ex_mul_op;
  logic                      id_ex_memread;
  logic                      id_ex_memwrite;
  logic                      id_ex_regwrite;
  logic                      mem_wb_regwrite;
  logic [`EXEC_REG_BITS-1:0] mem_wb_rd;
  logic [`EXEC_XLEN-1:0]     mem_wb_result;
  logic                      ex_stall;
  logic [`EXEC_XLEN-1:0]     ex_mem_result;
  logic [`EXEC_XLEN-1:0]     ex_mem_store_data;
  logic [`EXEC_XLEN-1:0]     ex_mem_pc;
  logic [`EXEC_REG_BITS-1:0] ex_mem_rd;
  logic                      ex_mem_memread;
  logic                      ex_mem_memwrite;
  logic                      ex_mem_regwrite;
  logic                      ex_mem_comp_res;

  // Expected EX/MEM images for the falling-edge compare
  exmem_t      exp_q[$];
  string       name_q[$];
  // Model view of the current EX/MEM contents
  exmem_t      last;
  int          errors;
  int          checks;
  int unsigned seed_val;
  instr_t      ins;

  execute dut0 (.*);

  initial begin
    bus = 1'b0;
    forever #(period_ns / 2) bus = ~bus;
  end

  // Watchdog allows one multiply plus slack per instruction
  initial begin
    #(total_instr * (`EXEC_MUL_CYCLES + 4) * period_ns);
    $display("the run timed out before all instructions completed, %0d errors", errors);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////////////////////

  // Forwarded source value with EX/MEM over MEM/WB over the file
  function automatic logic [`EXEC_XLEN-1:0] fwd_value(
    input logic [`EXEC_REG_BITS-1:0] rs,
    input logic [`EXEC_XLEN-1:0]     rf,
    input instr_t                    i
  );
    if (last.regwrite && !last.memread && last.rd != '0 && last.rd == rs) begin
      return last.result;
    end
    if (i.wb_regwrite && i.wb_rd != '0 && i.wb_rd == rs) begin
      return i.wb_result;
    end
    return rf;
  endfunction

  // Expected EX/MEM contents once the instruction is latched
  function automatic exmem_t expect_exmem(input instr_t i);
    logic [`EXEC_XLEN-1:0] a;
    logic [`EXEC_XLEN-1:0] r2;
    logic [`EXEC_XLEN-1:0] b;
    logic                  cmp;
    exmem_t                e;
    a   = fwd_value(i.rs1, i.rs1_data, i);
    r2  = fwd_value(i.rs2, i.rs2_data, i);
    b   = i.alusrc ? i.imm : r2;
    cmp = ref_comp(i.comp_op, a, b);
    e.result     = (i.unit == unit_mul) ? ref_mul(i.mul_op, a, b)
                                        : ref_alu(i.alu_op, a, b, i.pc);
    e.store_data = r2;
    e.pc         = i.pc;
    e.rd         = i.rd;
    e.memread    = i.memread;
    e.memwrite   = i.memwrite;
    // Failed compare drops the write
    e.regwrite   = i.regwrite && (!i.compare || cmp);
    e.comp_res   = cmp;
    return e;
  endfunction

  // Random ALU instruction whose sources 1..15 never meet destinations 16..31
  function automatic instr_t random_instr();
    instr_t      i;
    int unsigned kind;
    i = '0;
    i.pc       = $urandom & 32'hffff_fffc;
    i.rs1      = `EXEC_REG_BITS'(1 + $urandom % 15);
    i.rs2      = `EXEC_REG_BITS'(1 + $urandom % 15);
    i.rd       = `EXEC_REG_BITS'(16 + $urandom % 16);
    i.rs1_data = $urandom;
    i.rs2_data = $urandom;
    i.imm      = $urandom;
    i.alu_op   = alu_op_t'(4'($urandom % 13));
    i.comp_op  = comp_op_t'(3'($urandom % 6));
    i.alusrc   = 1'($urandom % 2);
    i.unit     = unit_alu;
    i.mul_op   = mul_low;
    // None, load or store
    kind       = $urandom % 3;
    i.memread  = (kind == 1);
    i.memwrite = (kind == 2);
    i.regwrite = 1'($urandom % 2);
    return i;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive(input instr_t i);
    id_ex_pc        <= i.pc;
    id_ex_rs1       <= i.rs1;
    id_ex_rs2       <= i.rs2;
    id_ex_rd        <= i.rd;
    id_ex_rs1_data  <= i.rs1_data;
    id_ex_rs2_data  <= i.rs2_data;
    id_ex_imm       <= i.imm;
    id_ex_alu_op    <= i.alu_op;
    id_ex_comp_op   <= i.comp_op;
    id_ex_compare   <= i.compare;
    id_ex_alusrc    <= i.alusrc;
    id_ex_unit      <= i.unit;
    id_ex_mul_op    <= i.mul_op;
    id_ex_memread   <= i.memread;
    id_ex_memwrite  <= i.memwrite;
    id_ex_regwrite  <= i.regwrite;
    mem_wb_regwrite <= i.wb_regwrite;
    mem_wb_rd       <= i.wb_rd;
    mem_wb_result   <= i.wb_result;
  endtask

  task automatic push_expect(input string name, input exmem_t e);
    exp_q.push_back(e);
    name_q.push_back(name);
  endtask

  // Present one instruction on a rising edge and follow it into EX/MEM
  task automatic run_instr(
    input string  name,
    input instr_t i,
    input logic   hold_dbg,
    input logic   hold_mem,
    input int     hold_cycles
  );
    exmem_t e;
    int     frozen;
    logic   first;
    logic   waiting;
    drive(i);
    dbg      <= hold_dbg;
    mem_hold <= hold_mem;
    e       = expect_exmem(i);
    frozen  = 0;
    first   = 1'b1;
    waiting = 1'b1;
    while (waiting) begin
      @(negedge bus);
      if (first && i.unit == unit_mul && !ex_stall) begin
        errors++;
        $display("multiply %s did not raise ex_stall in its first cycle", name);
      end
      first = 1'b0;
      if (!ex_stall && !dbg && !mem_hold) begin
        waiting = 1'b0;
      end else begin
        // EX/MEM keeps the older instruction on a frozen edge
        @(posedge bus);
        push_expect({name, " hold"}, last);
        frozen++;
        if (frozen >= hold_cycles) begin
          dbg      <= 1'b0;
          mem_hold <= 1'b0;
        end
      end
    end
    @(posedge bus);
    push_expect(name, e);
    last = e;
  endtask

  task automatic check_value(
    input string                 test,
    input string                 field,
    input logic [`EXEC_XLEN-1:0] exp,
    input logic [`EXEC_XLEN-1:0] act
  );
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  // Comparison on the falling edge away from the register update
  initial begin
    exmem_t e;
    string  n;
    forever begin
      @(negedge bus);
      while (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        check_value(n, "result", e.result, ex_mem_result);
        check_value(n, "store_data", e.store_data, ex_mem_store_data);
        check_value(n, "pc", e.pc, ex_mem_pc);
        check_value(n, "rd", `EXEC_XLEN'(e.rd), `EXEC_XLEN'(ex_mem_rd));
        check_value(n, "memread", `EXEC_XLEN'(e.memread), `EXEC_XLEN'(ex_mem_memread));
        check_value(n, "memwrite", `EXEC_XLEN'(e.memwrite), `EXEC_XLEN'(ex_mem_memwrite));
        check_value(n, "regwrite", `EXEC_XLEN'(e.regwrite), `EXEC_XLEN'(ex_mem_regwrite));
        check_value(n, "comp_res", `EXEC_XLEN'(e.comp_res), `EXEC_XLEN'(ex_mem_comp_res));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed_val = $urandom(32'h0657_dd6f);
    errors   = 0;
    checks   = 0;
    last     = '0;
    ins      = '0;
    reset    = 1'b1;
    dbg      = 1'b0;
    mem_hold = 1'b0;
    drive(ins);
    repeat (8) @(posedge bus);
    reset <= 1'b0;
    push_expect("reset", '0);
    @(negedge bus);
    if (ex_stall) begin
      errors++;
      $display("ex_stall is high right after reset");
    end
    @(posedge bus);

    // Independent ALU traffic
    repeat (num_alu) run_instr("alu", random_instr(), 1'b0, 1'b0, 0);

    // Back to back through EX/MEM
    ins = random_instr();
    ins.rd = 5;
    ins.regwrite = 1'b1;
    ins.memread = 1'b0;
    run_instr("fwd exmem producer", ins, 1'b0, 1'b0, 0);
    ins = random_instr();
    ins.rs1 = 5;
    ins.rs2 = 5;
    ins.alusrc = 1'b0;
    ins.alu_op = alu_add;
    run_instr("fwd exmem", ins, 1'b0, 1'b0, 0);
    // MEM/WB only
    ins = random_instr();
    ins.rs1 = 7;
    ins.rs2 = 7;
    ins.alusrc = 1'b0;
    ins.alu_op = alu_add;
    ins.wb_regwrite = 1'b1;
    ins.wb_rd = 7;
    ins.wb_result = $urandom;
    run_instr("fwd memwb", ins, 1'b0, 1'b0, 0);
    // Both stages match
    ins = random_instr();
    ins.rd = 9;
    ins.regwrite = 1'b1;
    ins.memread = 1'b0;
    run_instr("fwd both producer", ins, 1'b0, 1'b0, 0);
    ins = random_instr();
    ins.rs1 = 9;
    ins.rs2 = 9;
    ins.alusrc = 1'b0;
    ins.alu_op = alu_add;
    ins.wb_regwrite = 1'b1;
    ins.wb_rd = 9;
    ins.wb_result = $urandom;
    run_instr("fwd both", ins, 1'b0, 1'b0, 0);
    // x0 from either stage
    ins = random_instr();
    ins.rd = 0;
    ins.regwrite = 1'b1;
    ins.memread = 1'b0;
    ins.alu_op = alu_or;
    ins.alusrc = 1'b1;
    ins.imm = 32'h8000_0001;
    run_instr("fwd x0 producer", ins, 1'b0, 1'b0, 0);
    ins = random_instr();
    ins.rs1 = 0;
    ins.rs2 = 0;
    ins.rs1_data = '0;
    ins.rs2_data = '0;
    ins.alusrc = 1'b0;
    ins.alu_op = alu_add;
    ins.wb_regwrite = 1'b1;
    ins.wb_rd = 0;
    ins.wb_result = $urandom | 32'h1;
    run_instr("fwd x0", ins, 1'b0, 1'b0, 0);
    // Load in EX/MEM never forwards
    ins = random_instr();
    ins.rd = 11;
    ins.regwrite = 1'b1;
    ins.memread = 1'b1;
    ins.memwrite = 1'b0;
    run_instr("fwd load producer", ins, 1'b0, 1'b0, 0);
    ins = random_instr();
    ins.rs1 = 11;
    ins.rs2 = 11;
    ins.alusrc = 1'b0;
    ins.alu_op = alu_add;
    run_instr("fwd load", ins, 1'b0, 1'b0, 0);

    // Compare with equal operands now and then
    repeat (num_cmp) begin
      ins = random_instr();
      ins.compare = 1'b1;
      ins.regwrite = 1'b1;
      if ($urandom % 4 == 0) begin
        ins.alusrc = 1'b0;
        ins.rs2_data = ins.rs1_data;
      end
      run_instr("compare", ins, 1'b0, 1'b0, 0);
    end

    // Every multiply variant
    for (int op = 0; op < 4; op++) begin
      repeat (num_mul / 4) begin
        ins = random_instr();
        ins.unit = unit_mul;
        ins.mul_op = mul_op_t'(2'(op));
        ins.alusrc = 1'b0;
        ins.regwrite = 1'b1;
        ins.memread = 1'b0;
        ins.memwrite = 1'b0;
        run_instr($sformatf("mul op %0d", op), ins, 1'b0, 1'b0, 0);
      end
    end

    // Freeze from outside the stage
    run_instr("freeze dbg", random_instr(), 1'b1, 1'b0, 3);
    run_instr("freeze mem_hold", random_instr(), 1'b0, 1'b1, 2);
    run_instr("freeze both", random_instr(), 1'b1, 1'b1, 4);
    ins = random_instr();
    ins.unit = unit_mul;
    ins.mul_op = mul_h;
    ins.memread = 1'b0;
    ins.memwrite = 1'b0;
    run_instr("freeze mul short", ins, 1'b0, 1'b1, 5);
    // Held past the end of the multiply so done must wait
    ins.mul_op = mul_hsu;
    ins.rs1_data = $urandom;
    run_instr("freeze mul long", ins, 1'b1, 1'b0, `EXEC_MUL_CYCLES + 3);

    repeat (2) @(negedge bus);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : tb_execute

// ==== sim.f ====
+incdir+logic
+incdir+testbench
logic/exec_pkg.sv
logic/exmem_fwd_if.sv
logic/forwarding.sv
logic/alu.sv
logic/multiplier.sv
logic/execute.sv
testbench/tb_execute.sv

// ==== Bender.yml ====
package:
  name: execute_stage

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/exec_pkg.sv
      - logic/exmem_fwd_if.sv
      - logic/forwarding.sv
      - logic/alu.sv
      - logic/multiplier.sv
      - logic/execute.sv
  - target: test
    include_dirs:
      - logic
      - testbench
    files:
      - testbench/tb_execute.sv
